// ==== instExecTop.f ====
+incdir+tb
rtl/rvExecPkg.sv
rtl/controlDecoder.sv
rtl/operandUnit.sv
rtl/executeUnit.sv
rtl/instExecTop.sv
tb/instExecTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = instExecTb
FILELIST = instExecTop.f
OBJDIR   = obj_dir
LOG      = sim.log
FAILMSG  = Result: FAILED
PASSMSG  = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "no result line, run aborted"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb/refModel.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// expected result of one instruction, from the RV32I encoding rules
function automatic execResult_t expectResult(input inst_t w, input word_t pcIn,
                                             input word_t a, input word_t b);
  execResult_t e;
  word_t       iImm, sImm, bImm, uImm, jImm;
  word_t       val;  // value for ALU-type write-back
  logic        wr;
  logic        cond; // branch condition
  logic        bad;  // encoding outside the subset
  logic [2:0]  f3;
  logic [6:0]  f7;
  f3   = w[14:12];
  f7   = w[31:25];
  iImm = {{20{w[31]}}, w[31:20]};
  sImm = {{20{w[31]}}, w[31:25], w[11:7]};
  bImm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  uImm = {w[31:12], 12'h000};
  jImm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  e          = '0;
  e.nextPc   = pcIn + 32'd4; // fall through unless jump or taken branch
  e.memWdata = b;            // rs2 passed on as store data
  val        = '0;
  wr         = 1'b0;
  cond       = 1'b0;
  bad        = 1'b0;
  case (w[6:0])
    opLui: begin
      val = uImm;
      wr  = 1'b1;
    end
    opAuipc: begin
      val = pcIn + uImm;
      wr  = 1'b1;
    end
    opJal: begin
      e.regWrite = 1'b1;
      e.wbData   = pcIn + 32'd4; // link
      e.nextPc   = pcIn + jImm;
    end
    opJalr: begin
      if (f3 == 3'b000) begin
        e.regWrite = 1'b1;
        e.wbData   = pcIn + 32'd4;
        e.nextPc   = (a + iImm) & 32'hffff_fffe; // bit 0 dropped
      end else begin
        bad = 1'b1;
      end
    end
    opBranch: begin
      case (f3)
        3'b000:  cond = (a == b);
        3'b001:  cond = (a != b);
        3'b100:  cond = ($signed(a) < $signed(b));
        3'b101:  cond = ($signed(a) >= $signed(b));
        3'b110:  cond = (a < b);
        3'b111:  cond = (a >= b);
        default: bad = 1'b1;
      endcase
      if (cond) begin
        e.nextPc = pcIn + bImm;
      end
    end
    opLoad: begin
      case (f3)
        3'b000:  e.memExt = extSignByte; // lb
        3'b001:  e.memExt = extSignHalf; // lh
        3'b010:  e.memExt = extNone;     // lw
        3'b100:  e.memExt = extZeroByte; // lbu
        3'b101:  e.memExt = extZeroHalf; // lhu
        default: bad = 1'b1;
      endcase
      if (!bad) begin
        e.regWrite = 1'b1;
        e.memRw    = memRead;
        e.memAddr  = a + iImm;
      end
    end
    opStore: begin
      if (f3 == 3'b010) begin
        e.memRw   = memWrite; // sw only
        e.wmask   = 4'hf;
        e.memAddr = a + sImm;
      end else begin
        bad = 1'b1;
      end
    end
    opImm: begin
      case (f3)
        3'b000: val = a + iImm;
        3'b011: val = {31'b0, a < iImm}; // sltiu, imm sign-extended first
        3'b101: begin
          bad = (f7 != 7'b0100000); // srai, srli not in the subset
          val = word_t'($signed(a) >>> w[24:20]);
        end
        default: bad = 1'b1;
      endcase
      wr = !bad;
    end
    opReg: begin
      case ({f7, f3})
        {7'b0000000, 3'b000}: val = a + b;
        {7'b0100000, 3'b000}: val = a - b;
        {7'b0000000, 3'b100}: val = a ^ b;
        {7'b0000000, 3'b011}: val = {31'b0, a < b};
        default:              bad = 1'b1;
      endcase
      wr = !bad;
    end
    opSystem: begin
      if (f3 == 3'b000) begin
        e.ebreak = 1'b1; // no write, no access
      end else begin
        bad = 1'b1;
      end
    end
    default: bad = 1'b1;
  endcase
  if (wr) begin
    e.regWrite = 1'b1;
    e.wbData   = val;
  end
  e.illegal = bad;
  return e;
endfunction

`endif

// ==== tb/instExecTb.sv ====
module instExecTb import rvExecPkg::*; ();

  localparam int period    = 4;
  localparam int rstCycles = 3;
  localparam int numCycles = 2000;
  localparam int marginCyc = 100; // slack for the last result and summary

  logic        clk;
  logic        rstN;
  logic        issueValid;
  inst_t       inst;
  word_t       pc;
  word_t       rs1Val;
  word_t       rs2Val;
  logic        resValid;
  execResult_t res;

  integer      seed;
  int          valueErrors;
  int          protoErrors;
  execResult_t expQ[$];  // expected results in issue order
  execResult_t lastRes;  // value res must hold while idle
  logic        prevIssue;

  `include "refModel.svh"

  instExecTop u_dut (
    .clk        (clk),
    .rstN       (rstN),
    .issueValid (issueValid),
    .inst       (inst),
    .pc         (pc),
    .rs1Val     (rs1Val),
    .rs2Val     (rs2Val),
    .resValid   (resValid),
    .res        (res)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // watchdog
  initial begin
    #((rstCycles + numCycles + marginCyc) * period);
    $display("watchdog expired before the test sequence finished");
    $display("Result: FAILED");
    $finish;
  end

  task automatic checkField(input string name, input word_t got, input word_t exp);
    assert (got === exp)
      else begin
        valueErrors++;
        $display("FAIL %0t %s got=%h exp=%h", $time, name, got, exp);
      end
  endtask

  task automatic compareResult(input execResult_t exp);
    checkField("res.regWrite", word_t'(res.regWrite), word_t'(exp.regWrite));
    checkField("res.wbData", res.wbData, exp.wbData);
    checkField("res.nextPc", res.nextPc, exp.nextPc);
    checkField("res.memRw", word_t'(res.memRw), word_t'(exp.memRw));
    if (exp.memRw != memIdle) begin
      checkField("res.memAddr", res.memAddr, exp.memAddr); // only meaningful with a request
    end
    checkField("res.memWdata", res.memWdata, exp.memWdata);
    checkField("res.wmask", word_t'(res.wmask), word_t'(exp.wmask));
    checkField("res.memExt", word_t'(res.memExt), word_t'(exp.memExt));
    checkField("res.ebreak", word_t'(res.ebreak), word_t'(exp.ebreak));
    checkField("res.illegal", word_t'(res.illegal), word_t'(exp.illegal));
  endtask

  // outputs settled one time unit after the edge
  task automatic checkCycle();
    execResult_t exp;
    assert (resValid === prevIssue)
      else begin
        protoErrors++;
        $display("FAIL %0t resValid got=%b exp=%b", $time, resValid, prevIssue);
      end
    if (resValid === 1'b1) begin
      assert (expQ.size() > 0)
        else begin
          protoErrors++;
          $display("result at %0t with no instruction in flight", $time);
        end
      if (expQ.size() > 0) begin
        exp = expQ.pop_front();
        compareResult(exp);
      end
      lastRes = res;
    end else begin
      // zero after reset, otherwise the previous result
      assert (res === lastRes)
        else begin
          valueErrors++;
          $display("FAIL %0t res got=%h exp=%h", $time, res, lastRes);
        end
    end
  endtask

  // supported mnemonic with random fields, or a raw random word
  task automatic drawInst(output inst_t w);
    int         sel;
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    sel = {$random(seed)} % 26;
    w   = $random(seed);
    op  = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    case (sel)
      0:  op = opLui;
      1:  op = opAuipc;
      2:  op = opJal;
      3:  {op, f3} = {opJalr, 3'b000};
      4:  {op, f3} = {opBranch, 3'b000}; // beq
      5:  {op, f3} = {opBranch, 3'b001}; // bne
      6:  {op, f3} = {opBranch, 3'b100}; // blt
      7:  {op, f3} = {opBranch, 3'b101}; // bge
      8:  {op, f3} = {opBranch, 3'b110}; // bltu
      9:  {op, f3} = {opBranch, 3'b111}; // bgeu
      10: {op, f3} = {opLoad, 3'b000};
      11: {op, f3} = {opLoad, 3'b001};
      12: {op, f3} = {opLoad, 3'b010};
      13: {op, f3} = {opLoad, 3'b100};
      14: {op, f3} = {opLoad, 3'b101};
      15: {op, f3} = {opStore, 3'b010};
      16: {op, f3} = {opImm, 3'b000};    // addi
      17: {op, f3} = {opImm, 3'b011};    // sltiu
      18: {op, f3, f7} = {opImm, 3'b101, 7'b0100000}; // srai
      19: {op, f3, f7} = {opReg, 3'b000, 7'b0000000};
      20: {op, f3, f7} = {opReg, 3'b000, 7'b0100000}; // sub
      21: {op, f3, f7} = {opReg, 3'b100, 7'b0000000};
      22: {op, f3, f7} = {opReg, 3'b011, 7'b0000000};
      23: {op, f3, f7} = {opSystem, 3'b000, 7'b0000000};
      default: ; // raw word, mostly illegal
    endcase
    w = {f7, w[24:15], f3, w[11:7], op};
    if (sel == 23) begin
      w = 32'h0010_0073; // ebreak
    end
  endtask

  // bias towards equal and sign-differing pairs for branches
  task automatic drawOperands(output word_t a, output word_t b);
    int bias;
    bias = {$random(seed)} % 4;
    a    = $random(seed);
    case (bias)
      0:       b = a;
      1:       b = a ^ 32'h8000_0000; // signed and unsigned order disagree
      default: b = $random(seed);
    endcase
  endtask

  initial begin
    seed        = 32'h7ff2;
    valueErrors = 0;
    protoErrors = 0;
    rstN        = 1'b0;
    issueValid  = 1'b0;
    inst        = '0;
    pc          = '0;
    rs1Val      = '0;
    rs2Val      = '0;
    prevIssue   = 1'b0;
    lastRes     = '0;
    repeat (rstCycles) begin
      @(posedge clk);
      #1;
      checkCycle();
    end
    rstN = 1'b1;
    repeat (numCycles) begin
      @(posedge clk);
      #1;
      checkCycle();
      issueValid = ({$random(seed)} % 4) != 0; // about 3 in 4 cycles issue
      drawInst(inst);
      drawOperands(rs1Val, rs2Val);
      pc = $random(seed);
      pc[1:0] = 2'b00;
      if (issueValid) begin
        expQ.push_back(expectResult(inst, pc, rs1Val, rs2Val));
      end
      prevIssue = issueValid;
    end
    @(posedge clk);
    #1;
    checkCycle(); // drains the last one in flight
    $display("summary value errors %0d protocol errors %0d", valueErrors, protoErrors);
    if (valueErrors == 0 && protoErrors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/instExecTop.sv ====
module instExecTop import rvExecPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        issueValid,
  input  inst_t       inst,
  input  word_t       pc,
  input  word_t       rs1Val,
  input  word_t       rs2Val,
  output logic        resValid,
  output execResult_t res
);

  ctrl_t     ctrl;
  immSet_t   imms;
  cmpFlags_t flags;

  // decode and operand prep side by side, both combinational
  controlDecoder u_decoder (
    .opcode (inst[6:0]),
    .funct3 (inst[14:12]),
    .funct7 (inst[31:25]),
    .ctrl   (ctrl)
  );

  operandUnit u_operand (
    .inst   (inst),
    .rs1Val (rs1Val),
    .rs2Val (rs2Val),
    .imms   (imms),
    .flags  (flags)
  );

  executeUnit u_execute (
    .clk        (clk),
    .rstN       (rstN),
    .issueValid (issueValid),
    .ctrl       (ctrl),
    .imms       (imms),
    .flags      (flags),
    .funct3     (inst[14:12]), // branch condition select
    .pc         (pc),
    .rs1Val     (rs1Val),
    .rs2Val     (rs2Val),
    .resValid   (resValid),
    .res        (res)
  );

endmodule

// ==== rtl/executeUnit.sv ====
module executeUnit import rvExecPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        issueValid,
  input  ctrl_t       ctrl,
  input  immSet_t     imms,
  input  cmpFlags_t   flags,
  input  funct3_t     funct3,
  input  word_t       pc,
  input  word_t       rs1Val,
  input  word_t       rs2Val,
  output logic        resValid,
  output execResult_t res
);

  word_t       imm, opA, opB, aluRes, pcPlus4;
  logic        taken;
  logic        kill; // no architectural side effect
  execResult_t nextRes;

  always_comb begin
    case (ctrl.instType)
      typeI:   imm = imms.iImm;
      typeS:   imm = imms.sImm;
      typeB:   imm = imms.bImm;
      typeU:   imm = imms.uImm;
      typeJ:   imm = imms.jImm;
      default: imm = '0; // R and unknown carry no immediate
    endcase
  end

  assign opA = ctrl.aluAsel ? pc : rs1Val;
  assign opB = ctrl.aluBsel ? imm : rs2Val;

  always_comb begin
    case (ctrl.aluOp)
      aluAdd:    aluRes = opA + opB;
      aluPassB:  aluRes = opB;
      aluAddClr: aluRes = (opA + opB) & ~word_t'(1);
      aluSub:    aluRes = opA - opB;
      aluSltu:   aluRes = {{(xlen-1){1'b0}}, opA < opB};
      aluSlt:    aluRes = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
      aluXor:    aluRes = opA ^ opB;
      aluSra:    aluRes = word_t'($signed(opA) >>> opB[4:0]); // shamt only
      default:   aluRes = '0;
    endcase
  end

  // branch condition, ge forms are the inverted lt flags
  always_comb begin
    case (funct3)
      f3Beq:   taken = flags.eq;
      f3Bne:   taken = !flags.eq;
      f3Blt:   taken = flags.ltS;
      f3Bge:   taken = !flags.ltS;
      f3Bltu:  taken = flags.ltU;
      f3Bgeu:  taken = !flags.ltU;
      default: taken = 1'b0;
    endcase
    taken = taken && ctrl.isBranch;
  end

  assign pcPlus4 = pc + word_t'(4);
  assign kill    = ctrl.illegal || ctrl.ebreak;

  always_comb begin
    nextRes          = '0;
    nextRes.regWrite = ctrl.regWrite && !kill;
    case (ctrl.wbSel)
      wbAlu:     nextRes.wbData = aluRes;
      wbPcPlus4: nextRes.wbData = pcPlus4; // link address
      default:   nextRes.wbData = '0;      // load value is merged after memory
    endcase
    if (ctrl.jump) begin
      nextRes.nextPc = aluRes;
    end else if (taken) begin
      nextRes.nextPc = pc + imms.bImm;
    end else begin
      nextRes.nextPc = pcPlus4;
    end
    nextRes.memRw    = kill ? memIdle : ctrl.memRw;
    nextRes.memAddr  = aluRes;       // base + offset
    nextRes.memWdata = rs2Val;
    nextRes.wmask    = ctrl.wmask;
    nextRes.memExt   = ctrl.memExt;  // extension done by the load path
    nextRes.ebreak   = ctrl.ebreak;
    nextRes.illegal  = ctrl.illegal;
  end

  // single stage, res holds while nothing issues
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resValid <= 1'b0;
      res      <= '0;
    end else begin
      resValid <= issueValid;
      if (issueValid) begin
        res <= nextRes;
      end
    end
  end

  property pNoValidOutOfReset;
    @(posedge clk) !rstN |=> !resValid;
  endproperty
  assert property (pNoValidOutOfReset)
    else $error("resValid high on the cycle after reset");

  // decoder miss must reach the result with every side effect off
  property pIllegalIsInert;
    @(posedge clk) disable iff (!rstN)
      (resValid && res.illegal) |-> (!res.regWrite && res.memRw == memIdle);
  endproperty
  assert property (pIllegalIsInert)
    else $error("illegal result carries a write or memory access");

endmodule

// ==== rtl/operandUnit.sv ====
module operandUnit import rvExecPkg::*; (
  input  inst_t     inst,
  input  word_t     rs1Val,
  input  word_t     rs2Val,
  output immSet_t   imms,
  output cmpFlags_t flags
);

  logic signBit;

  assign signBit = inst[31]; // every format sign-extends from bit 31

  // I: inst[31:20]
  assign imms.iImm = {{20{signBit}}, inst[31:20]};

  // S: split across funct7 and rd fields
  assign imms.sImm = {{20{signBit}}, inst[31:25], inst[11:7]};

  // B: halfword offset, bit 0 always zero
  assign imms.bImm = {{19{signBit}}, signBit, inst[7], inst[30:25], inst[11:8], 1'b0};

  assign imms.uImm = {inst[31:12], 12'b0}; // upper 20, low bits clear

  // J: 21-bit offset, scrambled like B
  assign imms.jImm = {{11{signBit}}, signBit, inst[19:12], inst[20], inst[30:21], 1'b0};

  // compares run for every word, branch logic picks what it needs
  assign flags.eq  = (rs1Val == rs2Val);
  assign flags.ltS = ($signed(rs1Val) < $signed(rs2Val));
  assign flags.ltU = (rs1Val < rs2Val);

endmodule

// ==== rtl/controlDecoder.sv ====
module controlDecoder import rvExecPkg::*; (
  input  opcode_t opcode,
  input  funct3_t funct3,
  input  funct7_t funct7,
  output ctrl_t   ctrl
);

  ctrl_t     byOp, byF3, byF7; // one bundle per tier, zero when the tier misses
  logic      hitOp, hitF3, hitF7;
  instType_e instType;

  // tier 0, opcode alone
  always_comb begin
    byOp  = '0;
    hitOp = 1'b0;
    case (opcode)
      opLui: begin
        hitOp         = 1'b1;
        byOp.regWrite = 1'b1;
        byOp.aluBsel  = 1'b1;
        byOp.wbSel    = wbAlu;
        byOp.aluOp    = aluPassB; // upper imm straight through
      end
      opAuipc: begin
        hitOp         = 1'b1;
        byOp.regWrite = 1'b1;
        byOp.aluAsel  = 1'b1;
        byOp.aluBsel  = 1'b1;
        byOp.wbSel    = wbAlu;
      end
      opJal: begin
        hitOp         = 1'b1;
        byOp.regWrite = 1'b1;
        byOp.jump     = 1'b1;
        byOp.aluAsel  = 1'b1; // pc + jImm
        byOp.aluBsel  = 1'b1;
        byOp.wbSel    = wbPcPlus4;
      end
      default: ;
    endcase
  end

  // tier 1, opcode plus funct3
  always_comb begin
    byF3  = '0;
    hitF3 = 1'b0;
    case (opcode)
      opImm: begin
        hitF3 = (funct3 == f3Add) || (funct3 == f3Sltu); // addi, sltiu
        if (hitF3) begin
          byF3.regWrite = 1'b1;
          byF3.aluBsel  = 1'b1;
          byF3.wbSel    = wbAlu;
          byF3.aluOp    = (funct3 == f3Sltu) ? aluSltu : aluAdd;
        end
      end
      opJalr: begin
        hitF3 = (funct3 == f3Add);
        if (hitF3) begin
          byF3.regWrite = 1'b1;
          byF3.jump     = 1'b1;
          byF3.aluBsel  = 1'b1;
          byF3.wbSel    = wbPcPlus4;
          byF3.aluOp    = aluAddClr;
        end
      end
      opSystem: begin
        hitF3       = (funct3 == f3Add); // ebreak, funct12 not looked at
        byF3.ebreak = hitF3;
      end
      opStore: begin
        hitF3 = (funct3 == f3Sw);
        if (hitF3) begin
          byF3.memRw   = memWrite;
          byF3.aluBsel = 1'b1;
          byF3.wmask   = 4'b1111; // word store only
        end
      end
      opLoad: begin
        hitF3 = 1'b1;
        case (funct3)
          f3Lb:    byF3.memExt = extSignByte;
          f3Lh:    byF3.memExt = extSignHalf;
          f3Lw:    byF3.memExt = extNone;
          f3Lbu:   byF3.memExt = extZeroByte;
          f3Lhu:   byF3.memExt = extZeroHalf;
          default: hitF3 = 1'b0;
        endcase
        if (hitF3) begin
          byF3.regWrite = 1'b1;
          byF3.memRw    = memRead;
          byF3.aluBsel  = 1'b1;
          byF3.wbSel    = wbMem;
        end
      end
      opBranch: begin
        hitF3 = funct3 inside {f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
        if (hitF3) begin
          byF3.isBranch = 1'b1;
          byF3.aluAsel  = 1'b1; // target pc + bImm on the alu too
          byF3.aluBsel  = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // tier 2, full opcode/funct3/funct7 key
  always_comb begin
    byF7  = '0;
    hitF7 = 1'b1;
    case ({opcode, funct3, funct7})
      {opReg, f3Add, f7Base}:  byF7.aluOp = aluAdd;
      {opReg, f3Add, f7Alt}:   byF7.aluOp = aluSub;
      {opReg, f3Xor, f7Base}:  byF7.aluOp = aluXor;
      {opReg, f3Sltu, f7Base}: byF7.aluOp = aluSltu;
      {opImm, f3Sra, f7Alt}: begin
        byF7.aluOp   = aluSra;
        byF7.aluBsel = 1'b1; // shamt from iImm[4:0]
      end
      default: hitF7 = 1'b0;
    endcase
    if (hitF7) begin
      byF7.regWrite = 1'b1;
      byF7.wbSel    = wbAlu;
    end
  end

  // immediate layout per opcode
  always_comb begin
    case (opcode)
      opLui, opAuipc:        instType = typeU;
      opJal:                 instType = typeJ;
      opJalr, opLoad, opImm: instType = typeI;
      opBranch:              instType = typeB;
      opStore:               instType = typeS;
      opReg:                 instType = typeR;
      default:               instType = typeN;
    endcase
  end

  always_comb begin
    ctrl          = ctrl_t'(byOp | byF3 | byF7); // tiers are disjoint, OR merges them
    ctrl.instType = instType;
    ctrl.illegal  = !(hitOp || hitF3 || hitF7);
    // overlapping tiers would show up as both direction bits set
    assert (ctrl.memRw != 2'b11)
      else $error("decoder drives read and write together");
  end

endmodule

// ==== rtl/rvExecPkg.sv ====
package rvExecPkg;

  localparam int xlen = 32; // datapath width

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0]     inst_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      funct7_t;

  // major opcodes of the supported subset
  localparam opcode_t opLui    = 7'b0110111;
  localparam opcode_t opAuipc  = 7'b0010111;
  localparam opcode_t opJal    = 7'b1101111;
  localparam opcode_t opJalr   = 7'b1100111;
  localparam opcode_t opBranch = 7'b1100011;
  localparam opcode_t opLoad   = 7'b0000011;
  localparam opcode_t opStore  = 7'b0100011;
  localparam opcode_t opImm    = 7'b0010011;
  localparam opcode_t opReg    = 7'b0110011;
  localparam opcode_t opSystem = 7'b1110011;

  // funct3 codes, several share one encoding across opcodes
  localparam funct3_t f3Add  = 3'b000; // add/sub/addi/jalr/ebreak
  localparam funct3_t f3Sltu = 3'b011;
  localparam funct3_t f3Xor  = 3'b100;
  localparam funct3_t f3Sra  = 3'b101;
  localparam funct3_t f3Beq  = 3'b000;
  localparam funct3_t f3Bne  = 3'b001;
  localparam funct3_t f3Blt  = 3'b100;
  localparam funct3_t f3Bge  = 3'b101;
  localparam funct3_t f3Bltu = 3'b110;
  localparam funct3_t f3Bgeu = 3'b111;
  localparam funct3_t f3Lb   = 3'b000;
  localparam funct3_t f3Lh   = 3'b001;
  localparam funct3_t f3Lw   = 3'b010;
  localparam funct3_t f3Lbu  = 3'b100;
  localparam funct3_t f3Lhu  = 3'b101;
  localparam funct3_t f3Sw   = 3'b010;

  localparam funct7_t f7Base = 7'b0000000;
  localparam funct7_t f7Alt  = 7'b0100000; // sub, srai

  typedef enum logic [3:0] {
    aluAdd    = 4'd0,
    aluPassB  = 4'd1,
    aluAddClr = 4'd2, // jalr target
    aluSub    = 4'd3,
    aluSltu   = 4'd4,
    aluSlt    = 4'd5,
    aluXor    = 4'd6,
    aluSra    = 4'd7
  } aluOp_e;

  typedef enum logic [2:0] {typeR, typeI, typeS, typeB, typeU, typeJ, typeN} instType_e;

  typedef enum logic [1:0] {wbMem = 2'b00, wbAlu = 2'b01, wbPcPlus4 = 2'b10} wbSel_e;

  // one-hot style so ORed tiers can be checked for a clash
  typedef enum logic [1:0] {memIdle = 2'b00, memRead = 2'b10, memWrite = 2'b01} memRw_e;

  typedef enum logic [2:0] {
    extNone     = 3'b000,
    extSignByte = 3'b001,
    extSignHalf = 3'b010,
    extZeroByte = 3'b011,
    extZeroHalf = 3'b100
  } memExt_e;

  typedef struct packed {
    logic      regWrite;
    memRw_e    memRw;
    logic      ebreak;
    logic      jump;     // jal/jalr, next pc from alu
    logic      aluAsel;  // 1 = pc
    logic      aluBsel;  // 1 = immediate
    wbSel_e    wbSel;
    aluOp_e    aluOp;
    logic      isBranch;
    memExt_e   memExt;
    logic [3:0] wmask;
    instType_e instType;
    logic      illegal;
  } ctrl_t;

  typedef struct packed {
    word_t iImm;
    word_t sImm;
    word_t bImm;
    word_t uImm;
    word_t jImm;
  } immSet_t;

  typedef struct packed {
    logic eq;
    logic ltS;
    logic ltU;
  } cmpFlags_t;

  typedef struct packed {
    logic       regWrite;
    word_t      wbData;
    word_t      nextPc;
    memRw_e     memRw;
    word_t      memAddr;
    word_t      memWdata;
    logic [3:0] wmask;
    memExt_e    memExt;
    logic       ebreak;
    logic       illegal;
  } execResult_t;

endpackage
